// File: Makefile
SRCS := $(shell cat roce_test_stack.f)
BIN := obj_dir/Vtb_roce_test_stack

.PHONY: all run clean

all: run

$(BIN): roce_test_stack.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_roce_test_stack \
		-f roce_test_stack.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/payload_pattern_gen.sv
module payload_pattern_gen
  import roce_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  input  logic        launch,
  input  logic [31:0] dma_length,

  output axis_beat_t  m_payload,
  output logic        m_payload_valid,
  input  logic        m_payload_ready
);

  logic [31:0] byte_cnt;
  logic [31:0] msg_len;
  logic        is_last;
  logic [byte_idx_width_c-1:0] tail_bytes;
  logic [data_bytes_c-1:0]     tail_keep;

  // one launch starts one message, byte counter walks the length
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
      msg_len  <= '0;
    end else if (launch) begin
      byte_cnt <= '0;
      msg_len  <= dma_length;
    end else if (m_payload_valid && m_payload_ready) begin
      byte_cnt <= byte_cnt + 32'(data_bytes_c);
    end
  end

  assign m_payload_valid = (byte_cnt < msg_len);

  // 33 bits so a length near the top does not wrap
  assign is_last = ({1'b0, byte_cnt} + 33'(data_bytes_c)) >= {1'b0, msg_len};

  assign tail_bytes = msg_len[byte_idx_width_c-1:0];

  always_comb begin
    if (tail_bytes == '0) begin
      tail_keep = '1;
    end else begin
      tail_keep = (data_bytes_c'(1) << tail_bytes) - data_bytes_c'(1);
    end
  end

  always_comb begin
    m_payload.data = {~byte_cnt, byte_cnt};
    m_payload.keep = is_last ? tail_keep : '1;
    m_payload.last = is_last;
    m_payload.user = 1'b0;
  end

  // beat must not change or drop while stalled
  a_hold_beat: assert property (@(posedge clk) disable iff (rst)
    m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload));

endmodule

// File: design/qp_state_tracker.sv
module qp_state_tracker
  import roce_pkg::*;
#(
  parameter int ADDR_OFFSET_WIDTH = 18
) (
  input  logic        clk,
  input  logic        rst,

  input  qp_cfg_t     cfg,
  input  logic        start,
  input  logic        stop,
  input  pmtu_t       pmtu,
  input  logic        beat_done,

  output logic        launch,
  output qp_state_t   cur_state,
  output logic [31:0] msg_count
);

  logic [3:0]  pmtu_shift;
  logic [11:0] pmtu_mask;
  logic        pmtu_legal;

  logic [31:0] dma_length;
  logic [23:0] rem_qpn;
  logic [23:0] rem_psn;
  logic [31:0] r_key;
  logic [63:0] addr_base;
  logic [ADDR_OFFSET_WIDTH-1:0] addr_off;
  logic [31:0] n_transfers;

  logic [31:0] psn_step;
  logic        stopped;

  always_comb begin
    pmtu_legal = 1'b1;
    case (pmtu)
      13'd256: begin
        pmtu_shift = 4'd8;
        pmtu_mask  = 12'h0ff;
      end
      13'd512: begin
        pmtu_shift = 4'd9;
        pmtu_mask  = 12'h1ff;
      end
      13'd1024: begin
        pmtu_shift = 4'd10;
        pmtu_mask  = 12'h3ff;
      end
      13'd2048: begin
        pmtu_shift = 4'd11;
        pmtu_mask  = 12'h7ff;
      end
      13'd4096: begin
        pmtu_shift = 4'd12;
        pmtu_mask  = 12'hfff;
      end
      default: begin
        pmtu_legal = 1'b0;
        pmtu_shift = 4'd12;
        pmtu_mask  = 12'hfff;
      end
    endcase
  end

  // packets per message, a partial packet counts as one
  assign psn_step = (dma_length >> pmtu_shift) + 32'(|(dma_length[11:0] & pmtu_mask));

  // all ones marks a stopped chain
  assign stopped = &msg_count;

  // qp payload, loaded on start and advanced per message
  always_ff @(posedge clk) begin
    if (start) begin
      dma_length  <= cfg.dma_length;
      rem_qpn     <= cfg.rem_qpn;
      rem_psn     <= cfg.rem_psn;
      r_key       <= cfg.r_key;
      addr_base   <= cfg.rem_addr;
      n_transfers <= cfg.n_transfers;
    end else if (beat_done) begin
      rem_psn <= rem_psn + psn_step[23:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      launch    <= 1'b0;
      msg_count <= '0;
      addr_off  <= '0;
    end else begin
      launch <= 1'b0;
      if (start) begin
        launch    <= 1'b1;
        msg_count <= '0;
        addr_off  <= '0;
      end else if (beat_done) begin
        addr_off <= addr_off + dma_length[ADDR_OFFSET_WIDTH-1:0];
        if (!stopped) begin
          msg_count <= msg_count + 32'd1;
          launch    <= (msg_count < n_transfers - 32'd1);
        end
      end
      if (stop) begin
        launch    <= 1'b0;
        msg_count <= '1;
      end
    end
  end

  always_comb begin
    cur_state.dma_length = dma_length;
    cur_state.rem_qpn    = rem_qpn;
    cur_state.rem_psn    = rem_psn;
    cur_state.r_key      = r_key;
    cur_state.rem_addr   = addr_base + 64'(addr_off);
  end

  a_pmtu_legal: assert property (@(posedge clk) disable iff (rst)
    (start || beat_done) |-> pmtu_legal);

endmodule

// File: design/roce_pkg.sv
package roce_pkg;

  // payload stream geometry
  localparam int data_width_c = 64;
  localparam int data_bytes_c = data_width_c / 8;
  localparam int byte_idx_width_c = $clog2(data_bytes_c);

  // IANA port for RoCE v2
  localparam logic [15:0] roce_udp_port_c = 16'h12B7;

  // PMTU in bytes, 256 to 4096
  typedef logic [12:0] pmtu_t;

  typedef struct packed {
    logic [data_width_c-1:0] data;
    logic [data_bytes_c-1:0] keep;
    logic                    last;
    logic                    user;
  } axis_beat_t;

  // only the header fields the steering path carries
  typedef struct packed {
    logic [31:0] ip_source_ip;
    logic [31:0] ip_dest_ip;
    logic [15:0] udp_source_port;
    logic [15:0] udp_dest_port;
    logic [15:0] udp_length;
  } udp_hdr_t;

  // queue pair init values from the connection setup
  typedef struct packed {
    logic [31:0] dma_length;
    logic [23:0] rem_qpn;
    logic [23:0] rem_psn;
    logic [31:0] r_key;
    logic [63:0] rem_addr;
    logic [31:0] n_transfers;
  } qp_cfg_t;

  typedef struct packed {
    logic [31:0] dma_length;
    logic [23:0] rem_qpn;
    logic [23:0] rem_psn;
    logic [31:0] r_key;
    logic [63:0] rem_addr;
  } qp_state_t;

endpackage

// File: design/roce_test_stack.sv
module roce_test_stack
  import roce_pkg::*;
#(
  parameter logic [15:0] ROCE_PORT         = roce_udp_port_c,
  parameter int          ADDR_OFFSET_WIDTH = 18
) (
  input  logic        clk,
  input  logic        rst,

  input  udp_hdr_t    s_hdr,
  input  logic        s_hdr_valid,
  output logic        s_hdr_ready,
  input  axis_beat_t  s_payload,
  input  logic        s_payload_valid,
  output logic        s_payload_ready,

  output udp_hdr_t    cm_hdr,
  output logic        cm_hdr_valid,
  input  logic        cm_hdr_ready,
  output axis_beat_t  cm_payload,
  output logic        cm_payload_valid,
  input  logic        cm_payload_ready,

  output udp_hdr_t    roce_hdr,
  output logic        roce_hdr_valid,
  input  logic        roce_hdr_ready,
  output axis_beat_t  roce_payload,
  output logic        roce_payload_valid,
  input  logic        roce_payload_ready,

  input  qp_cfg_t     qp_cfg,
  input  logic        start,
  input  logic        stop,
  input  pmtu_t       pmtu,

  output axis_beat_t  m_payload,
  output logic        m_payload_valid,
  input  logic        m_payload_ready,

  output qp_state_t   cur_state,
  output logic [31:0] msg_count
);

  logic launch;
  logic beat_done;

  // message boundary seen by the qp tracker
  assign beat_done = m_payload_valid && m_payload_ready && m_payload.last;

  udp_rx_steer #(
    .ROCE_PORT(ROCE_PORT)
  ) u_steer (
    .clk               (clk),
    .rst               (rst),
    .s_hdr             (s_hdr),
    .s_hdr_valid       (s_hdr_valid),
    .s_hdr_ready       (s_hdr_ready),
    .s_payload         (s_payload),
    .s_payload_valid   (s_payload_valid),
    .s_payload_ready   (s_payload_ready),
    .cm_hdr            (cm_hdr),
    .cm_hdr_valid      (cm_hdr_valid),
    .cm_hdr_ready      (cm_hdr_ready),
    .cm_payload        (cm_payload),
    .cm_payload_valid  (cm_payload_valid),
    .cm_payload_ready  (cm_payload_ready),
    .roce_hdr          (roce_hdr),
    .roce_hdr_valid    (roce_hdr_valid),
    .roce_hdr_ready    (roce_hdr_ready),
    .roce_payload      (roce_payload),
    .roce_payload_valid(roce_payload_valid),
    .roce_payload_ready(roce_payload_ready)
  );

  payload_pattern_gen u_gen (
    .clk            (clk),
    .rst            (rst),
    .launch         (launch),
    .dma_length     (cur_state.dma_length),
    .m_payload      (m_payload),
    .m_payload_valid(m_payload_valid),
    .m_payload_ready(m_payload_ready)
  );

  qp_state_tracker #(
    .ADDR_OFFSET_WIDTH(ADDR_OFFSET_WIDTH)
  ) u_qp (
    .clk      (clk),
    .rst      (rst),
    .cfg      (qp_cfg),
    .start    (start),
    .stop     (stop),
    .pmtu     (pmtu),
    .beat_done(beat_done),
    .launch   (launch),
    .cur_state(cur_state),
    .msg_count(msg_count)
  );

endmodule

// File: design/udp_rx_steer.sv
module udp_rx_steer
  import roce_pkg::*;
#(
  parameter logic [15:0] ROCE_PORT = roce_udp_port_c
) (
  input  logic       clk,
  input  logic       rst,

  input  udp_hdr_t   s_hdr,
  input  logic       s_hdr_valid,
  output logic       s_hdr_ready,
  input  axis_beat_t s_payload,
  input  logic       s_payload_valid,
  output logic       s_payload_ready,

  output udp_hdr_t   cm_hdr,
  output logic       cm_hdr_valid,
  input  logic       cm_hdr_ready,
  output axis_beat_t cm_payload,
  output logic       cm_payload_valid,
  input  logic       cm_payload_ready,

  output udp_hdr_t   roce_hdr,
  output logic       roce_hdr_valid,
  input  logic       roce_hdr_ready,
  output axis_beat_t roce_payload,
  output logic       roce_payload_valid,
  input  logic       roce_payload_ready
);

  logic hdr_is_roce;
  logic sel_cm;
  logic sel_roce;
  logic last_accepted;

  // header stays on the bus until the last payload beat
  assign hdr_is_roce = (s_hdr.udp_dest_port == ROCE_PORT);

  assign cm_hdr_valid   = s_hdr_valid && !hdr_is_roce;
  assign roce_hdr_valid = s_hdr_valid && hdr_is_roce;
  assign s_hdr_ready    = hdr_is_roce ? roce_hdr_ready : cm_hdr_ready;

  always_comb begin
    cm_hdr = s_hdr;
    roce_hdr = s_hdr;
    roce_hdr.udp_dest_port = ROCE_PORT;
  end

  assign last_accepted = s_payload_valid && s_payload_ready && s_payload.last;

  // per-frame select, retaken at frame boundaries
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_cm   <= 1'b0;
      sel_roce <= 1'b0;
    end else if (s_payload_valid) begin
      if ((!sel_cm && !sel_roce) || last_accepted) begin
        sel_cm   <= !hdr_is_roce;
        sel_roce <= hdr_is_roce;
      end
    end else begin
      sel_cm   <= 1'b0;
      sel_roce <= 1'b0;
    end
  end

  assign cm_payload         = s_payload;
  assign roce_payload       = s_payload;
  assign cm_payload_valid   = sel_cm && s_payload_valid;
  assign roce_payload_valid = sel_roce && s_payload_valid;
  assign s_payload_ready    = (sel_cm && cm_payload_ready) || (sel_roce && roce_payload_ready);

  a_one_sink: assert property (@(posedge clk) disable iff (rst)
    !(cm_payload_valid && roce_payload_valid));

endmodule

// File: roce_test_stack.f
design/roce_pkg.sv
design/udp_rx_steer.sv
design/payload_pattern_gen.sv
design/qp_state_tracker.sv
design/roce_test_stack.sv
tests/tb_clock.sv
tests/tb_roce_test_stack.sv

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// File: tests/tb_roce_test_stack.sv
module tb_roce_test_stack
  import roce_pkg::*;
();

  localparam int n_chains = 7;
  localparam int n_frames = 12;

  logic        clk;
  logic        rst;
  udp_hdr_t    s_hdr, cm_hdr, roce_hdr;
  axis_beat_t  s_payload, cm_payload, roce_payload, m_payload;
  logic        s_hdr_valid, s_hdr_ready, s_payload_valid, s_payload_ready;
  logic        cm_hdr_valid, cm_hdr_ready, cm_payload_valid, cm_payload_ready;
  logic        roce_hdr_valid, roce_hdr_ready, roce_payload_valid, roce_payload_ready;
  qp_cfg_t     qp_cfg;
  logic        start, stop;
  pmtu_t       pmtu;
  logic        m_payload_valid, m_payload_ready;
  qp_state_t   cur_state;
  logic [31:0] msg_count;

  int cyc;
  int limit;
  bit rnd_ready;
  int n_mismatch, n_other, n_count_err;
  int sent_cm, sent_roce, got_cm, got_roce;
  int done_chains;
  int chain_len[n_chains];
  int chain_pmtu[n_chains];
  int chain_n[n_chains];

  // steer select model
  bit sel_held, sel_roce;

  // model of the generator and qp state
  logic [31:0] m_len, m_c, m_rkey;
  logic [23:0] m_psn, m_qpn;
  logic [63:0] m_base, m_acc;
  int m_pmtu, m_msgs, m_n;
  int expect_rise = -1;
  bit m_stopped, prev_valid, state_check, chain_end;

  tb_clock #(.PERIOD(100)) u_clk (.clk(clk));

  roce_test_stack dut (.*);

  function automatic bit ref_to_roce(input logic [15:0] port);
    return port == 16'd4791;
  endfunction

  function automatic axis_beat_t ref_beat(input logic [31:0] c, input logic [31:0] len);
    axis_beat_t b;
    int rem;
    rem = int'(len % 32'd8);
    b.data = {~c, c};
    b.last = (33'(c) + 33'd8) >= 33'(len);
    b.keep = 8'hff;
    if (b.last && rem != 0) begin
      b.keep = 8'hff >> (8 - rem);
    end
    b.user = 1'b0;
    return b;
  endfunction

  // packets per message, rounded up
  function automatic logic [23:0] ref_psn_step(input logic [31:0] len, input int pmtu_b);
    longint n;
    n = (longint'(len) + longint'(pmtu_b) - 64'sd1) / longint'(pmtu_b);
    return 24'(n);
  endfunction

  function automatic logic [63:0] ref_addr(input logic [63:0] base, input logic [63:0] acc);
    return base + (acc % 64'h40000);
  endfunction

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH %s exp %0h got %0h at cycle %0d", name, exp, got, cyc);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    cm_hdr_ready <= 1'b0;
    cm_payload_ready <= 1'b0;
    roce_hdr_ready <= 1'b0;
    roce_payload_ready <= 1'b0;
    m_payload_ready <= 1'b1;
    forever begin
      @(posedge clk);
      cm_hdr_ready <= 1'($urandom);
      cm_payload_ready <= 1'($urandom);
      roce_hdr_ready <= 1'($urandom);
      roce_payload_ready <= 1'($urandom);
      m_payload_ready <= rnd_ready ? 1'($urandom) : 1'b1;
    end
  end

  // compare process, sampled mid cycle
  always @(negedge clk) begin
    axis_beat_t exp_b;
    udp_hdr_t exp_h;
    logic exp_rdy;
    bit to_roce, relaunch;
    if (!rst) begin
      to_roce = ref_to_roce(s_hdr.udp_dest_port);
      check_val("cm_hdr_valid", 128'(s_hdr_valid && !to_roce), 128'(cm_hdr_valid));
      check_val("roce_hdr_valid", 128'(s_hdr_valid && to_roce), 128'(roce_hdr_valid));
      if (s_hdr_valid) begin
        check_val("s_hdr_ready", 128'(to_roce ? roce_hdr_ready : cm_hdr_ready),
                  128'(s_hdr_ready));
        exp_h = s_hdr;
        exp_h.udp_dest_port = 16'd4791;
        if (to_roce) begin
          check_val("roce_hdr", 128'(exp_h), 128'(roce_hdr));
        end else begin
          check_val("cm_hdr", 128'(s_hdr), 128'(cm_hdr));
        end
      end
      exp_rdy = sel_held && (sel_roce ? roce_payload_ready : cm_payload_ready);
      check_val("cm_payload_valid", 128'(s_payload_valid && sel_held && !sel_roce),
                128'(cm_payload_valid));
      check_val("roce_payload_valid", 128'(s_payload_valid && sel_held && sel_roce),
                128'(roce_payload_valid));
      if (s_payload_valid) begin
        check_val("s_payload_ready", 128'(exp_rdy), 128'(s_payload_ready));
        if (cm_payload_valid && cm_payload_ready) begin
          check_val("cm_payload", 128'(s_payload), 128'(cm_payload));
          got_cm++;
        end
        if (roce_payload_valid && roce_payload_ready) begin
          check_val("roce_payload", 128'(s_payload), 128'(roce_payload));
          got_roce++;
        end
        // select is retaken on the next edge
        if (!sel_held || (exp_rdy && s_payload.last)) begin
          sel_held = 1'b1;
          sel_roce = to_roce;
        end
      end else begin
        sel_held = 1'b0;
      end
      if (state_check) begin
        state_check = 1'b0;
        check_val("cur_state.dma_length", 128'(m_len), 128'(cur_state.dma_length));
        check_val("cur_state.rem_qpn", 128'(m_qpn), 128'(cur_state.rem_qpn));
        check_val("cur_state.r_key", 128'(m_rkey), 128'(cur_state.r_key));
        check_val("cur_state.rem_psn", 128'(m_psn), 128'(cur_state.rem_psn));
        check_val("cur_state.rem_addr", 128'(ref_addr(m_base, m_acc)),
                  128'(cur_state.rem_addr));
        check_val("msg_count", 128'(m_stopped ? 32'hffff_ffff : 32'(m_msgs)),
                  128'(msg_count));
        if (chain_end) begin
          done_chains++;
        end
      end
      if (m_payload_valid && !prev_valid) begin
        if (expect_rise < 0) begin
          n_other++;
          $display("payload valid rose with no launch due at cycle %0d", cyc);
        end else begin
          check_val("first valid cycle", 128'(expect_rise), 128'(cyc));
        end
        expect_rise = -1;
      end
      prev_valid = m_payload_valid;
      if (start) begin
        m_len = qp_cfg.dma_length;
        m_c = 0;
        m_qpn = qp_cfg.rem_qpn;
        m_rkey = qp_cfg.r_key;
        m_psn = qp_cfg.rem_psn;
        m_base = qp_cfg.rem_addr;
        m_acc = 0;
        m_n = int'(qp_cfg.n_transfers);
        m_pmtu = int'(pmtu);
        m_msgs = 0;
        m_stopped = 1'b0;
        expect_rise = cyc + 2;
        state_check = 1'b1;
        chain_end = 1'b0;
      end
      if (stop) begin
        m_stopped = 1'b1;
      end
      if (m_payload_valid && m_payload_ready) begin
        exp_b = ref_beat(m_c, m_len);
        check_val("m_payload.data", 128'(exp_b.data), 128'(m_payload.data));
        check_val("m_payload.keep", 128'(exp_b.keep), 128'(m_payload.keep));
        check_val("m_payload.last", 128'(exp_b.last), 128'(m_payload.last));
        check_val("m_payload.user", 128'(exp_b.user), 128'(m_payload.user));
        m_c = m_c + 32'd8;
        if (exp_b.last) begin
          relaunch = !m_stopped && (m_msgs < m_n - 1);
          m_psn = m_psn + ref_psn_step(m_len, m_pmtu);
          m_acc = m_acc + 64'(m_len);
          if (!m_stopped) begin
            m_msgs++;
          end
          m_c = 0;
          state_check = 1'b1;
          chain_end = !relaunch;
          if (relaunch) begin
            expect_rise = cyc + 2;
          end
        end
      end
    end
  end

  task automatic run_chain(input int len, input int n, input int pmtu_b, input bit with_stop);
    qp_cfg_t cfg;
    int want;
    cfg.dma_length = 32'(len);
    cfg.rem_qpn = 24'($urandom);
    cfg.rem_psn = 24'($urandom);
    cfg.r_key = $urandom;
    cfg.rem_addr = {$urandom, $urandom};
    cfg.n_transfers = 32'(n);
    want = done_chains + 1;
    @(posedge clk);
    qp_cfg <= cfg;
    pmtu <= 13'(pmtu_b);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (with_stop) begin
      // land the stop inside the second message
      while (m_msgs < 1) @(posedge clk);
      repeat (3) @(posedge clk);
      stop <= 1'b1;
      @(posedge clk);
      stop <= 1'b0;
    end
    while (done_chains < want) @(posedge clk);
  endtask

  initial begin
    udp_hdr_t h;
    axis_beat_t b;
    bit to_roce, acc;
    int nb, i, f, k, total;
    void'($urandom(32'h4db9));
    rst <= 1'b1;
    s_hdr <= '0;
    s_hdr_valid <= 1'b0;
    s_payload <= '0;
    s_payload_valid <= 1'b0;
    qp_cfg <= '0;
    start <= 1'b0;
    stop <= 1'b0;
    pmtu <= 13'd256;
    rnd_ready = 1'b0;
    chain_pmtu = '{256, 512, 1024, 2048, 4096, 256, 4096};
    chain_n = '{3, 3, 3, 3, 3, 2, 2};
    for (k = 0; k < 5; k++) begin
      chain_len[k] = $urandom_range(3 * chain_pmtu[k], 1);
    end
    chain_len[5] = 8;
    // long enough that the address offset wraps
    chain_len[6] = 150000;
    total = n_frames * 4 + 6 * 50;
    for (k = 0; k < n_chains; k++) begin
      total += ((chain_len[k] + 7) / 8) * chain_n[k];
    end
    limit = total * 4 + 1000;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (f = 0; f < n_frames; f++) begin
      to_roce = 1'($urandom);
      nb = $urandom_range(4, 1);
      h.ip_source_ip = $urandom;
      h.ip_dest_ip = $urandom;
      h.udp_source_port = 16'($urandom);
      h.udp_dest_port = to_roce ? 16'd4791 : 16'($urandom_range(4790, 0));
      h.udp_length = 16'(8 + nb * 8);
      if (to_roce) begin
        sent_roce += nb;
      end else begin
        sent_cm += nb;
      end
      @(posedge clk);
      s_hdr <= h;
      s_hdr_valid <= 1'b1;
      for (i = 0; i < nb; i++) begin
        b.data = {$urandom, $urandom};
        b.keep = 8'($urandom);
        b.last = (i == nb - 1);
        b.user = 1'($urandom);
        s_payload <= b;
        s_payload_valid <= 1'b1;
        acc = 1'b0;
        while (!acc) begin
          @(negedge clk);
          acc = s_payload_valid && s_payload_ready;
          @(posedge clk);
        end
      end
      s_payload_valid <= 1'b0;
      s_hdr_valid <= 1'b0;
    end
    if (got_cm != sent_cm || got_roce != sent_roce) begin
      n_count_err++;
      $display("MISMATCH steered beats exp cm %0h roce %0h got cm %0h roce %0h",
               sent_cm, sent_roce, got_cm, got_roce);
    end

    for (k = 0; k < n_chains; k++) begin
      rnd_ready = (k % 2 == 1);
      run_chain(chain_len[k], chain_n[k], chain_pmtu[k], 1'b0);
    end
    rnd_ready = 1'b1;
    run_chain(400, 6, 512, 1'b1);
    // no valid may follow a stopped chain
    repeat (20) @(posedge clk);

    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other + n_count_err);
    if (n_mismatch + n_other + n_count_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    @(posedge clk);
    while (cyc < limit) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles with %0d errors so far", limit,
             n_mismatch + n_other + n_count_err);
    $display("Result: FAILED");
    $finish;
  end

endmodule
